//--- filelist.f
cpu_mem_pkg.sv
data_mem.sv
mem_arbiter.sv
fetch_unit.sv
load_store_unit.sv
mem_subsystem.sv
tb_mem_subsystem.sv

//--- memory.mem
// one dword per line in hex, dword 0 first, in memory byte order.
// the leftmost byte of a line is address offset 0 of that dword.
004080c0ffbf7f3f
014181c1febe7e3e
024282c2fdbd7d3d
034383c3fcbc7c3c
044484c4fbbb7b3b
054585c5faba7a3a
064686c6f9b97939
074787c7f8b87838
084888c8f7b77737
094989c9f6b67636
0a4a8acaf5b57535
0b4b8bcbf4b47434
0c4c8cccf3b37333
0d4d8dcdf2b27232
0e4e8ecef1b17131
0f4f8fcff0b07030
105090d0efaf6f2f
115191d1eeae6e2e
125292d2edad6d2d
135393d3ecac6c2c
145494d4ebab6b2b
155595d5eaaa6a2a
165696d6e9a96929
175797d7e8a86828
185898d8e7a76727
195999d9e6a66626
1a5a9adae5a56525
1b5b9bdbe4a46424
1c5c9cdce3a36323
1d5d9ddde2a26222
1e5e9edee1a16121
1f5f9fdfe0a06020
2060a0e0df9f5f1f
2161a1e1de9e5e1e
2262a2e2dd9d5d1d
2363a3e3dc9c5c1c
2464a4e4db9b5b1b
2565a5e5da9a5a1a
2666a6e6d9995919
2767a7e7d8985818
2868a8e8d7975717
2969a9e9d6965616
2a6aaaead5955515
2b6babebd4945414
2c6cacecd3935313
2d6dadedd2925212
2e6eaeeed1915111
2f6fafefd0905010
3070b0f0cf8f4f0f
3171b1f1ce8e4e0e
3272b2f2cd8d4d0d
3373b3f3cc8c4c0c
3474b4f4cb8b4b0b
3575b5f5ca8a4a0a
3676b6f6c9894909
3777b7f7c8884808
3878b8f8c7874707
3979b9f9c6864606
3a7abafac5854505
3b7bbbfbc4844404
3c7cbcfcc3834303
3d7dbdfdc2824202
3e7ebefec1814101
3f7fbfffc0804000

//--- tb_mem_subsystem.sv
module tb_mem_subsystem;
    timeunit 1ns;
    timeprecision 100ps;
    import cpu_mem_pkg::*;

    localparam int data_words     = 64;
    localparam int index_bits     = $clog2(data_words);
    localparam int timeout_cycles = 40;
    localparam int port_fetch     = 0;
    localparam int port_lsu       = 1;
    localparam int port_both      = 2;  // lsu at addr, fetch at addr + 4.
    localparam int port_reset     = 3;

    typedef struct {
        string           name;
        int              port;
        dword_t          addr;
        mem_store_type_t store_type;
        dword_t          data;
        bit              rand_offset;  // random offset inside the dword.
    } entry_t;

    logic     clk;
    logic     reset;
    logic     fetch_req;
    dword_t   fetch_addr;
    logic     fetch_ack;
    inst_t    fetch_inst;
    logic     lsu_req;
    lsu_req_t lsu_cmd;
    logic     lsu_ack;
    dword_t   lsu_rdata;

    logic [63:0] model_mem[data_words];  // memory byte order, offset 0 in bits 63:56.
    entry_t      stim[$];
    integer      seed = 49386;
    bit          last_lsu;                // last grant went to the lsu.
    time         fetch_done;
    time         lsu_done;

    mem_subsystem #(.data_words(data_words)) i_dut (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_addr(fetch_addr),
        .fetch_ack (fetch_ack),
        .fetch_inst(fetch_inst),
        .lsu_req   (lsu_req),
        .lsu_cmd   (lsu_cmd),
        .lsu_ack   (lsu_ack),
        .lsu_rdata (lsu_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_inst(input string name, input inst_t expected, input inst_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_dword(input string name, input dword_t expected, input dword_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // whole dword with offset 0 moved to bits 7:0.
    function automatic dword_t expected_load(input dword_t addr);
        dword_t result;
        for (int k = 0; k < 8; k++) begin
            result[8*k +: 8] = model_mem[addr[index_bits+2:3]][63-8*k -: 8];
        end
        return result;
    endfunction

    function automatic inst_t expected_inst(input dword_t addr);
        dword_t word;
        word = expected_load(addr);
        return addr[2] ? word[63:32] : word[31:0];
    endfunction

    // data byte j goes to offset base + j.
    task automatic update_model(input dword_t addr, input mem_store_type_t st, input dword_t data);
        int base;
        int count;
        base  = (st == STORE_BYTE) ? int'(addr[2:0]) : (st == STORE_WORD) ? 4 * addr[2] : 0;
        count = (st == STORE_BYTE) ? 1 : (st == STORE_WORD) ? 4 : (st == STORE_DWORD) ? 8 : 0;
        for (int j = 0; j < count; j++) begin
            model_mem[addr[index_bits+2:3]][63-8*(base+j) -: 8] = data[8*j +: 8];
        end
    endtask

    task automatic wait_ack(input bit lsu_port, input logic level);
        int cycles = 0;
        while ((lsu_port ? lsu_ack : fetch_ack) !== level) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("%s ack did not reach %b within %0d cycles",
                         lsu_port ? "lsu" : "fetch", level, timeout_cycles);
                stop_with_failure();
            end
        end
    endtask

    task automatic do_fetch(input dword_t addr, output inst_t inst);
        @(posedge clk);
        #1;
        fetch_addr = addr;
        fetch_req  = 1'b1;
        wait_ack(1'b0, 1'b1);
        fetch_done = $time;
        inst       = fetch_inst;
        fetch_req  = 1'b0;
        wait_ack(1'b0, 1'b0);
    endtask

    task automatic do_lsu(input lsu_req_t cmd, output dword_t rdata);
        @(posedge clk);
        #1;
        lsu_cmd = cmd;
        lsu_req = 1'b1;
        wait_ack(1'b1, 1'b1);
        lsu_done = $time;
        rdata    = lsu_rdata;
        lsu_req  = 1'b0;
        wait_ack(1'b1, 1'b0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        $readmemh("memory.mem", model_mem);
        last_lsu = 1'b1;  // fetch wins the first tie.
        if (fetch_ack !== 1'b0 || lsu_ack !== 1'b0) begin
            $display("an ack output is not low right after reset");
            stop_with_failure();
        end
    endtask

    task automatic add_entry(input string n, input int p, input dword_t a,
                             input mem_store_type_t st, input dword_t d, input bit r);
        stim.push_back('{name: n, port: p, addr: a, store_type: st, data: d, rand_offset: r});
    endtask

    task automatic run_entry(input entry_t e);
        lsu_req_t cmd;
        dword_t   addr;
        dword_t   rdata;
        dword_t   exp_rdata;
        inst_t    inst;
        inst_t    exp_inst;
        int       off;
        addr = e.addr;
        if (e.rand_offset) begin
            off  = $random(seed) & 7;
            addr = addr + ((e.store_type == STORE_WORD) ? (off & 4) : off);
        end
        cmd = '{addr: addr, data: e.data, store_type: e.store_type};
        case (e.port)
            port_fetch: begin
                exp_inst = expected_inst(addr);
                do_fetch(addr, inst);
                check_inst(e.name, exp_inst, inst);
                last_lsu = 1'b0;
            end
            port_lsu: begin
                exp_rdata = expected_load(addr);
                update_model(addr, e.store_type, e.data);
                do_lsu(cmd, rdata);
                check_dword(e.name, exp_rdata, rdata);
                last_lsu = 1'b1;
            end
            port_both: begin
                // the client not granted last is served first.
                if (last_lsu) begin
                    exp_inst = expected_inst(e.addr + 4);
                end
                exp_rdata = expected_load(addr);
                update_model(addr, e.store_type, e.data);
                if (!last_lsu) begin
                    exp_inst = expected_inst(e.addr + 4);
                end
                fork
                    do_fetch(e.addr + 4, inst);
                    do_lsu(cmd, rdata);
                join
                if ((fetch_done < lsu_done) != last_lsu) begin
                    $display("%s finished in the wrong order for round robin", e.name);
                    stop_with_failure();
                end
                check_inst({e.name, "_fetch"}, exp_inst, inst);
                check_dword({e.name, "_lsu"}, exp_rdata, rdata);
                // the loser is granted second, so the last grant is unchanged.
            end
            default: apply_reset();
        endcase
    endtask

    initial begin
        reset      = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        lsu_req    = 1'b0;
        lsu_cmd    = '0;
        add_entry("fetch_low", port_fetch, 'h20, NO_STORE, '0, 1'b0);
        add_entry("fetch_high", port_fetch, 'h24, NO_STORE, '0, 1'b0);
        add_entry("load_image", port_lsu, 'h48, NO_STORE, '0, 1'b0);
        add_entry("load_again", port_lsu, 'h48, NO_STORE, '0, 1'b0);
        add_entry("store_byte", port_lsu, 'h80, STORE_BYTE, 64'h11223344556677a5, 1'b1);
        add_entry("check_byte", port_lsu, 'h80, NO_STORE, '0, 1'b0);
        add_entry("store_byte_2", port_lsu, 'h88, STORE_BYTE, 64'h000000000000005c, 1'b1);
        add_entry("check_byte_2", port_lsu, 'h88, NO_STORE, '0, 1'b0);
        add_entry("store_word", port_lsu, 'h90, STORE_WORD, 64'h99887766c3d2e1f0, 1'b1);
        add_entry("check_word", port_lsu, 'h90, NO_STORE, '0, 1'b0);
        add_entry("store_word_2", port_lsu, 'h98, STORE_WORD, 64'h0000000013579bdf, 1'b1);
        add_entry("check_word_2", port_lsu, 'h98, NO_STORE, '0, 1'b0);
        add_entry("store_dword", port_lsu, 'ha0, STORE_DWORD, 64'h0123456789abcdef, 1'b0);
        add_entry("check_dword", port_lsu, 'ha0, NO_STORE, '0, 1'b0);
        add_entry("fetch_stored", port_fetch, 'ha4, NO_STORE, '0, 1'b0);
        add_entry("pair_load", port_both, 'h100, NO_STORE, '0, 1'b0);
        add_entry("pair_word", port_both, 'h108, STORE_WORD, 64'h00000000deadbeef, 1'b1);
        add_entry("pair_dword", port_both, 'h110, STORE_DWORD, 64'hfedcba9876543210, 1'b0);
        add_entry("pair_byte", port_both, 'h118, STORE_BYTE, 64'h00000000000000e7, 1'b1);
        add_entry("check_pair_word", port_lsu, 'h108, NO_STORE, '0, 1'b0);
        add_entry("pair_after_lsu", port_both, 'h120, STORE_WORD, 64'h00000000a1b2c3d4, 1'b1);
        add_entry("pair_again", port_both, 'h128, NO_STORE, '0, 1'b0);
        add_entry("store_before_reset", port_lsu, 'h1f0, STORE_DWORD, 64'h5555aaaa3333cccc, 1'b0);
        add_entry("second_reset", port_reset, '0, NO_STORE, '0, 1'b0);
        add_entry("load_after_reset", port_lsu, 'h1f0, NO_STORE, '0, 1'b0);
        add_entry("fetch_after_reset", port_fetch, 'h1f4, NO_STORE, '0, 1'b0);
        apply_reset();
        foreach (stim[i]) begin
            run_entry(stim[i]);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- mem_subsystem.sv
module mem_subsystem #(
    parameter data_words = 'h4000
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  fetch_req,
    input  cpu_mem_pkg::dword_t   fetch_addr,
    output logic                  fetch_ack,
    output cpu_mem_pkg::inst_t    fetch_inst,

    input  logic                  lsu_req,
    input  cpu_mem_pkg::lsu_req_t lsu_cmd,
    output logic                  lsu_ack,
    output cpu_mem_pkg::dword_t   lsu_rdata
);
    import cpu_mem_pkg::*;

    // client channels into the arbiter.
    logic      fetch_mreq_req;
    mem_req_t  fetch_mreq;
    logic      fetch_mack;
    logic      lsu_mreq_req;
    mem_req_t  lsu_mreq;
    logic      lsu_mack;
    mem_word_t arb_rdata;  // shared, only the owner samples it.

    // arbiter to memory.
    logic      mem_en;
    mem_req_t  mem_req;
    mem_word_t mem_rdata;

    fetch_unit i_fetch (
        .clk     (clk),
        .reset   (reset),
        .req     (fetch_req),
        .addr    (fetch_addr),
        .ack     (fetch_ack),
        .inst    (fetch_inst),
        .mreq_req(fetch_mreq_req),
        .mreq    (fetch_mreq),
        .mreq_ack(fetch_mack),
        .mrdata  (arb_rdata)
    );

    load_store_unit i_lsu (
        .clk     (clk),
        .reset   (reset),
        .req     (lsu_req),
        .cmd     (lsu_cmd),
        .ack     (lsu_ack),
        .rdata   (lsu_rdata),
        .mreq_req(lsu_mreq_req),
        .mreq    (lsu_mreq),
        .mreq_ack(lsu_mack),
        .mrdata  (arb_rdata)
    );

    mem_arbiter i_arbiter (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_mreq_req),
        .fetch_mreq(fetch_mreq),
        .fetch_ack (fetch_mack),
        .lsu_req   (lsu_mreq_req),
        .lsu_mreq  (lsu_mreq),
        .lsu_ack   (lsu_mack),
        .rdata     (arb_rdata),
        .mem_en    (mem_en),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    data_mem #(
        .data_words(data_words)
    ) i_mem (
        .clk  (clk),
        .reset(reset),
        .en   (mem_en),
        .req  (mem_req),
        .rdata(mem_rdata)
    );

endmodule

//--- load_store_unit.sv
module load_store_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  cpu_mem_pkg::lsu_req_t  cmd,
    output logic                   ack,
    output cpu_mem_pkg::dword_t    rdata,
    output logic                   mreq_req,
    output cpu_mem_pkg::mem_req_t  mreq,
    input  logic                   mreq_ack,
    input  cpu_mem_pkg::mem_word_t mrdata
);
    import cpu_mem_pkg::*;

    lsu_req_t   cmd_q;
    mem_word_t  wdata;
    logic [7:0] byte_en;
    logic [2:0] offset;
    dword_t     rdata_next;
    logic       start;
    logic       done;

    assign start  = req && !ack && !mreq_req && !mreq_ack;
    assign done   = mreq_req && mreq_ack && !ack;
    assign offset = cmd_q.addr[2:0];

    // place store data into memory lanes.
    always_comb begin
        wdata   = '0;
        byte_en = '0;
        unique case (cmd_q.store_type)
            STORE_BYTE: begin
                wdata.bytes[offset] = cmd_q.data[7:0];
                byte_en[offset]     = 1'b1;
            end
            STORE_WORD: begin
                // low data byte goes to the lowest address of the half.
                wdata.halves[offset[2]] = {
                    cmd_q.data[7:0], cmd_q.data[15:8], cmd_q.data[23:16], cmd_q.data[31:24]
                };
                byte_en = offset[2] ? 8'hf0 : 8'h0f;
            end
            STORE_DWORD: begin
                for (int k = 0; k < 8; k++) begin
                    wdata.bytes[k] = cmd_q.data[8*k+:8];
                end
                byte_en = 8'hff;
            end
            NO_STORE: ;  // read only.
        endcase
    end

    assign mreq = '{addr: cmd_q.addr, wdata: wdata, byte_en: byte_en};

    // old word back to core order, offset 0 in bits 7:0.
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            rdata_next[8*k+:8] = mrdata.bytes[k];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mreq_req <= 1'b0;
            ack      <= 1'b0;
        end else begin
            if (start) begin
                mreq_req <= 1'b1;
            end else if (ack && !req) begin
                mreq_req <= 1'b0;
            end

            if (done) begin
                ack <= 1'b1;
            end else if (ack && !req && !mreq_req && !mreq_ack) begin
                ack <= 1'b0;  // arbiter has let go.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cmd_q <= cmd;
        end
        if (done) begin
            rdata <= rdata_next;
        end
    end

endmodule

//--- fetch_unit.sv
module fetch_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  cpu_mem_pkg::dword_t    addr,
    output logic                   ack,
    output cpu_mem_pkg::inst_t     inst,
    output logic                   mreq_req,
    output cpu_mem_pkg::mem_req_t  mreq,
    input  logic                   mreq_ack,
    input  cpu_mem_pkg::mem_word_t mrdata
);
    import cpu_mem_pkg::*;

    dword_t      addr_q;
    inst_t       inst_next;
    logic [31:0] half;
    logic        start;
    logic        done;

    // new request only once both channels are idle.
    assign start = req && !ack && !mreq_req && !mreq_ack;
    assign done  = mreq_req && mreq_ack && !ack;

    // a fetch never writes.
    assign mreq = '{addr: addr_q, wdata: '0, byte_en: '0};

    // address bit 2 picks the half, then put offset 0 in the low byte.
    assign half      = mrdata.halves[addr_q[2]];
    assign inst_next = {half[7:0], half[15:8], half[23:16], half[31:24]};

    always_ff @(posedge clk) begin
        if (reset) begin
            mreq_req <= 1'b0;
            ack      <= 1'b0;
        end else begin
            if (start) begin
                mreq_req <= 1'b1;
            end else if (ack && !req) begin
                mreq_req <= 1'b0;  // caller is done.
            end

            if (done) begin
                ack <= 1'b1;
            end else if (ack && !req && !mreq_req && !mreq_ack) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= addr;
        end
        if (done) begin
            inst <= inst_next;
        end
    end

endmodule

//--- mem_arbiter.sv
module mem_arbiter (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   fetch_req,
    input  cpu_mem_pkg::mem_req_t  fetch_mreq,
    output logic                   fetch_ack,

    input  logic                   lsu_req,
    input  cpu_mem_pkg::mem_req_t  lsu_mreq,
    output logic                   lsu_ack,

    output cpu_mem_pkg::mem_word_t rdata,

    output logic                   mem_en,
    output cpu_mem_pkg::mem_req_t  mem_req,
    input  cpu_mem_pkg::mem_word_t mem_rdata
);

    localparam logic [1:0] st_idle   = 2'd0;  // waiting for a request.
    localparam logic [1:0] st_access = 2'd1;  // strobe to the memory.
    localparam logic [1:0] st_read   = 2'd2;  // memory word arrives.
    localparam logic [1:0] st_ack    = 2'd3;  // ack held until req drops.

    logic [1:0] state;
    logic       owner;      // 0 is fetch, 1 is lsu. doubles as the last grant.
    logic       grant_lsu;
    logic       owner_req;

    // on a tie the client not granted last wins.
    assign grant_lsu = lsu_req && (!fetch_req || !owner);
    assign owner_req = owner ? lsu_req : fetch_req;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            owner <= 1'b1;  // so fetch wins the first tie.
        end else begin
            unique case (state)
                st_idle: begin
                    if (fetch_req || lsu_req) begin
                        owner <= grant_lsu;
                        state <= st_access;
                    end
                end
                st_access: state <= st_read;
                st_read:   state <= st_ack;
                st_ack: begin
                    if (!owner_req) begin
                        state <= st_idle;  // owner finished its handshake.
                    end
                end
            endcase
        end
    end

    // hold the word for the owner until the handshake ends.
    always_ff @(posedge clk) begin
        if (state == st_read) begin
            rdata <= mem_rdata;
        end
    end

    assign mem_en  = (state == st_access);
    assign mem_req = owner ? lsu_mreq : fetch_mreq;

    assign fetch_ack = (state == st_ack) && !owner;
    assign lsu_ack   = (state == st_ack) && owner;

endmodule

//--- data_mem.sv
module data_mem #(
    parameter data_words = 'h4000  // number of stored dwords.
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   en,
    input  cpu_mem_pkg::mem_req_t  req,
    output cpu_mem_pkg::mem_word_t rdata
);
    import cpu_mem_pkg::*;

    localparam index_bits = $clog2(data_words);

    logic      [63:0]           mem[data_words];
    logic      [index_bits-1:0] index;
    mem_word_t                  old_word;
    mem_word_t                  new_word;

    // dword index, the low three bits pick a byte inside the word.
    assign index    = req.addr[index_bits+2:3];
    assign old_word = mem[index];

    // merge the enabled bytes into the stored word.
    always_comb begin
        new_word = old_word;
        for (int k = 0; k < 8; k++) begin
            if (req.byte_en[k]) begin
                new_word.bytes[k] = req.wdata.bytes[k];
            end
        end
    end

    initial begin
        $readmemh("memory.mem", mem);
    end

    // read returns the word from before the write.
    always @(posedge clk) begin
        if (reset) begin
            $readmemh("memory.mem", mem);  // image reload, simulation only.
        end else if (en) begin
            rdata      <= old_word;
            mem[index] <= new_word;
        end
    end

endmodule

//--- cpu_mem_pkg.sv
package cpu_mem_pkg;

    // width of a store, NO_STORE is a plain load.
    typedef enum logic [1:0] {
        NO_STORE,
        STORE_BYTE,
        STORE_WORD,
        STORE_DWORD
    } mem_store_type_t;

    typedef logic [63:0] dword_t;  // addresses, store data and load results.
    typedef logic [31:0] inst_t;   // one fetched instruction.

    // one stored memory word in memory byte order.
    // address offset 0 sits in the most significant lane.
    typedef union packed {
        logic [0:7][7:0]  bytes;   // bytes[k] is the byte at offset k.
        logic [0:1][31:0] halves;  // halves[0] is the lower-address half.
    } mem_word_t;

    // command from the core to the load/store port.
    typedef struct packed {
        dword_t          addr;
        dword_t          data;        // store data, least significant byte first in memory.
        mem_store_type_t store_type;
    } lsu_req_t;

    // one memory access as seen by the arbiter and the memory.
    typedef struct packed {
        dword_t     addr;
        mem_word_t  wdata;    // already in memory order.
        logic [7:0] byte_en;  // bit k enables offset k, all zero is a read.
    } mem_req_t;

endpackage
